/* tb.f */
source/core_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/writeback.sv
source/exec_core.sv
testbench/exec_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;
    import core_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  result_valid;
    logic [data_width-1:0] result;
    logic                  overflow;

    // stimulus table
    string                 tbl_name[$];
    logic [31:0]           tbl_instr[$];
    logic [data_width-1:0] tbl_word[$];
    logic                  tbl_flag[$];

    // results still in flight
    string                 exp_name[$];
    logic [data_width-1:0] exp_word[$];
    logic                  exp_flag[$];
    int                    exp_cycle[$];

    int                    cycle;
    int                    timeout_limit;
    int                    seed;
    logic [31:0]           rnd;
    string                 got_name;
    logic [data_width-1:0] want_word;
    logic                  want_flag;
    int                    issued_at;

    exec_core dut (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .result_valid(result_valid), .result(result), .overflow(overflow)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(string name, logic [data_width-1:0] expected,
                              logic [data_width-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: result expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: overflow expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_test(string name, logic [31:0] word,
                            logic [data_width-1:0] res, logic ovf);
        tbl_name.push_back(name);
        tbl_instr.push_back(word);
        tbl_word.push_back(res);
        tbl_flag.push_back(ovf);
    endtask

    // instruction encoders with bit 31 held at 0
    function automatic logic [31:0] enc_base(base_sub_e sub, int rt, int ra, int rb);
        return {1'b0, op_ty_base, rt[4:0], ra[4:0], rb[4:0], 5'b0, sub};
    endfunction

    function automatic logic [31:0] enc_imm15(opcode_e op, int rt, int ra, int imm);
        return {1'b0, op, rt[4:0], ra[4:0], imm[14:0]};
    endfunction

    function automatic logic [31:0] enc_movi(int rt, int imm);
        return {1'b0, op_movi, rt[4:0], imm[19:0]};
    endfunction

    function automatic logic [31:0] enc_ls(logic [7:0] sub, int rt, int ra, int rb);
        return {1'b0, op_ty_ls, rt[4:0], ra[4:0], rb[4:0], 2'b0, sub};
    endfunction

    task automatic build_table();
        seed = 32'haede;
        rnd  = $random(seed);
        add_test("movi_pos", enc_movi(1, 32'h0f0f0), 32'h0000f0f0, 1'b0);
        add_test("movi_pat", enc_movi(3, 32'h3c3c3), 32'h0003c3c3, 1'b0);
        add_test("movi_random", enc_movi(9, int'(rnd)), {{12{rnd[19]}}, rnd[19:0]}, 1'b0);
        add_test("movi_neg", enc_movi(2, 32'h80000), 32'hfff80000, 1'b0);
        // dependent chain where each reads the result just before it
        add_test("add_chain", enc_base(sub_add, 4, 1, 2), 32'hfff8f0f0, 1'b0);
        add_test("sub_chain", enc_base(sub_sub, 5, 4, 2), 32'h0000f0f0, 1'b0);
        add_test("and_chain", enc_base(sub_and, 6, 5, 3), 32'h0000c0c0, 1'b0);
        add_test("or_chain", enc_base(sub_or, 7, 6, 2), 32'hfff8c0c0, 1'b0);
        add_test("xor_chain", enc_base(sub_xor, 8, 7, 3), 32'hfffb0303, 1'b0);
        add_test("movi_one", enc_movi(12, 1), 32'h00000001, 1'b0);
        add_test("slli_31", enc_base(sub_slli, 10, 12, 31), 32'h80000000, 1'b0);
        add_test("sub_ovf", enc_base(sub_sub, 11, 10, 12), 32'h7fffffff, 1'b1);
        add_test("add_ovf", enc_base(sub_add, 13, 11, 12), 32'h80000000, 1'b1);
        add_test("add_small", enc_base(sub_add, 14, 12, 12), 32'h00000002, 1'b0);
        add_test("addi_neg", enc_imm15(op_addi, 15, 12, -2), 32'hffffffff, 1'b0);
        add_test("ori_zext", enc_imm15(op_ori, 16, 2, 32'h7001), 32'hfff87001, 1'b0);
        add_test("xori_zext", enc_imm15(op_xori, 17, 16, 32'h7fff), 32'hfff80ffe, 1'b0);
        add_test("slli_0", enc_base(sub_slli, 18, 7, 0), 32'hfff8c0c0, 1'b0);
        add_test("srli_4", enc_base(sub_srli, 19, 7, 4), 32'h0fff8c0c, 1'b0);
        add_test("srli_31", enc_base(sub_srli, 20, 10, 31), 32'h00000001, 1'b0);
        add_test("rotri_4", enc_base(sub_rotri, 21, 3, 4), 32'h30003c3c, 1'b0);
        add_test("rotri_31", enc_base(sub_rotri, 22, 3, 31), 32'h00078786, 1'b0);
        add_test("rotri_0", enc_base(sub_rotri, 23, 3, 0), 32'h0003c3c3, 1'b0);
        // store reports its address, load returns the stored word
        add_test("swi", enc_imm15(op_swi, 8, 12, 7), 32'h00000008, 1'b0);
        add_test("lwi", enc_imm15(op_lwi, 24, 12, 7), 32'hfffb0303, 1'b0);
        add_test("addi_base", enc_imm15(op_addi, 25, 0, 32'h40), 32'h00000040, 1'b0);
        add_test("sw", enc_ls(ls_sw, 13, 25, 0), 32'h00000040, 1'b0);
        add_test("lw", enc_ls(ls_lw, 26, 25, 0), 32'h80000000, 1'b0);
        add_test("undef_op", {1'b0, 6'h3f, 5'd27, 20'h12345}, 32'h00000000, 1'b0);
        add_test("undef_ls", enc_ls(8'h05, 28, 12, 12), 32'h00000000, 1'b0);
    endtask

    // results are registered on the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle > timeout_limit)
        begin
            $display("timeout after %0d cycles with %0d results still missing",
                     cycle, exp_word.size());
            abort_run();
        end
        if (!reset && result_valid)
        begin
            if (exp_word.size() == 0)
            begin
                $display("result_valid pulsed with no instruction outstanding");
                abort_run();
            end
            got_name  = exp_name.pop_front();
            want_word = exp_word.pop_front();
            want_flag = exp_flag.pop_front();
            issued_at = exp_cycle.pop_front();
            check_word(got_name, want_word, result);
            check_flag(got_name, want_flag, overflow);
            if (cycle - issued_at != 2)
            begin
                $display("ERROR %s: latency expected 2, actual %0d", got_name,
                         cycle - issued_at);
                abort_run();
            end
        end
    end

    initial
    begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        cycle       = 0;
        build_table();
        timeout_limit = tbl_instr.size() * 4 + 50;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // one instruction per cycle, no gaps
        for (int i = 0; i < tbl_instr.size(); i++)
        begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= tbl_instr[i];
            exp_name.push_back(tbl_name[i]);
            exp_word.push_back(tbl_word[i]);
            exp_flag.push_back(tbl_flag[i]);
            exp_cycle.push_back(cycle);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;

        while (exp_word.size() != 0)
        begin
            @(negedge clk);
        end
        // catch any stray strobe
        repeat (4) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* source/exec_core.sv */
`timescale 1ns/1ps

module exec_core #(
    parameter int dmem_addr_width = 6
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            instr_valid,
    input  logic [31:0]                     instr,
    output logic                            result_valid,
    output logic [core_pkg::data_width-1:0] result,
    output logic                            overflow
);
    import core_pkg::*;

    logic [reg_addr_width-1:0] read_a_addr;
    logic [reg_addr_width-1:0] read_b_addr;
    logic [data_width-1:0]     read_a_data;
    logic [data_width-1:0]     read_b_data;
    opcode_e                   opcode;
    base_sub_e                 sub_op_base;
    ls_sub_e                   sub_op_ls;
    logic [data_width-1:0]     imm;
    logic                      src1_imm;
    logic                      src2_imm;
    logic [reg_addr_width-1:0] rd_addr;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic                      exec_valid;
    logic [data_width-1:0]     src1;
    logic [data_width-1:0]     src2;
    logic [data_width-1:0]     alu_result;
    logic                      alu_overflow;
    logic [data_width-1:0]     load_data;
    logic                      rf_write_en;
    logic [reg_addr_width-1:0] rf_write_addr;
    logic [data_width-1:0]     rf_write_data;

    // operand selects
    assign src1 = src1_imm ? imm : read_a_data;
    assign src2 = src2_imm ? imm : read_b_data;

    inst_decode u_decode (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .read_a_addr(read_a_addr), .read_b_addr(read_b_addr),
        .opcode(opcode), .sub_op_base(sub_op_base), .sub_op_ls(sub_op_ls),
        .imm(imm), .src1_imm(src1_imm), .src2_imm(src2_imm), .rd_addr(rd_addr),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .exec_valid(exec_valid)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .read_a_addr(read_a_addr), .read_b_addr(read_b_addr),
        .read_a_data(read_a_data), .read_b_data(read_b_data),
        .write_en(rf_write_en), .write_addr(rf_write_addr), .write_data(rf_write_data)
    );

    alu u_alu (
        .reset(reset), .enable_execute(exec_valid),
        .opcode(opcode), .sub_op_base(sub_op_base), .sub_op_ls(sub_op_ls),
        .src1(src1), .src2(src2),
        .alu_result(alu_result), .alu_overflow(alu_overflow)
    );

    // store data is rt, read on port b
    data_mem #(.dmem_addr_width(dmem_addr_width)) u_dmem (
        .clk(clk), .reset(reset), .addr(alu_result),
        .write_en(mem_write), .write_data(read_b_data), .read_data(load_data)
    );

    writeback u_wb (
        .clk(clk), .reset(reset), .exec_valid(exec_valid),
        .reg_write(reg_write), .mem_read(mem_read), .rd_addr(rd_addr),
        .alu_result(alu_result), .alu_overflow(alu_overflow), .load_data(load_data),
        .rf_write_en(rf_write_en), .rf_write_addr(rf_write_addr),
        .rf_write_data(rf_write_data),
        .result_valid(result_valid), .result(result), .overflow(overflow)
    );

endmodule

/* source/writeback.sv */
`timescale 1ns/1ps

module writeback (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                exec_valid,
    input  logic                                reg_write,
    input  logic                                mem_read,
    input  logic [core_pkg::reg_addr_width-1:0] rd_addr,
    input  logic [core_pkg::data_width-1:0]     alu_result,
    input  logic                                alu_overflow,
    input  logic [core_pkg::data_width-1:0]     load_data,
    output logic                                rf_write_en,
    output logic [core_pkg::reg_addr_width-1:0] rf_write_addr,
    output logic [core_pkg::data_width-1:0]     rf_write_data,
    output logic                                result_valid,
    output logic [core_pkg::data_width-1:0]     result,
    output logic                                overflow
);

    // loads take memory data, everything else the alu
    assign rf_write_data = mem_read ? load_data : alu_result;
    assign rf_write_addr = rd_addr;
    assign rf_write_en   = exec_valid && reg_write;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= exec_valid;
        end
    end

    // stores report the address here
    always_ff @(posedge clk)
    begin
        if (exec_valid)
        begin
            result   <= rf_write_data;
            overflow <= alu_overflow;
        end
    end

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
    parameter int dmem_addr_width = 6
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::data_width-1:0] addr,
    input  logic                            write_en,
    input  logic [core_pkg::data_width-1:0] write_data,
    output logic [core_pkg::data_width-1:0] read_data
);
    import core_pkg::*;

    localparam int depth = 1 << dmem_addr_width;

    logic [data_width-1:0]      mem [depth];
    logic [dmem_addr_width-1:0] word_addr;

    // byte address to word index
    assign word_addr = addr[dmem_addr_width+1:2];
    assign read_data = mem[word_addr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (write_en)
        begin
            mem[word_addr] <= write_data;
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                            reset,
    input  logic                            enable_execute,
    input  core_pkg::opcode_e               opcode,
    input  core_pkg::base_sub_e             sub_op_base,
    input  core_pkg::ls_sub_e               sub_op_ls,
    input  logic [core_pkg::data_width-1:0] src1,
    input  logic [core_pkg::data_width-1:0] src2,
    output logic [core_pkg::data_width-1:0] alu_result,
    output logic                            alu_overflow
);
    import core_pkg::*;

    logic [data_width:0]     add_out;
    logic [data_width:0]     sub_out;
    logic [2*data_width-1:0] rotate;

    // returns {overflow, sum}; overflow is carry into msb xor carry out
    function automatic logic [data_width:0] add_ovf(
        input logic [data_width-1:0] x,
        input logic [data_width-1:0] y,
        input logic                  cin
    );
        logic [data_width-1:0] low;
        logic [1:0]            top;
        low = {1'b0, x[data_width-2:0]} + {1'b0, y[data_width-2:0]} + cin;
        top = x[data_width-1] + y[data_width-1] + low[data_width-1];
        return {low[data_width-1] ^ top[1], top[0], low[data_width-2:0]};
    endfunction

    assign add_out = add_ovf(src1, src2, 1'b0);
    // subtract as src1 + ~src2 + 1
    assign sub_out = add_ovf(src1, ~src2, 1'b1);
    assign rotate  = {src1, src1} >> src2[4:0];

    always_comb
    begin
        alu_result   = '0;
        alu_overflow = 1'b0;
        if (!reset && enable_execute)
        begin
            case (opcode)
                op_ty_base:
                begin
                    case (sub_op_base)
                        sub_add:
                        begin
                            alu_result   = add_out[data_width-1:0];
                            alu_overflow = add_out[data_width];
                        end
                        sub_sub:
                        begin
                            alu_result   = sub_out[data_width-1:0];
                            alu_overflow = sub_out[data_width];
                        end
                        sub_and:   alu_result = src1 & src2;
                        sub_or:    alu_result = src1 | src2;
                        sub_xor:   alu_result = src1 ^ src2;
                        sub_slli:  alu_result = src1 << src2[4:0];
                        sub_srli:  alu_result = src1 >> src2[4:0];
                        sub_rotri: alu_result = rotate[data_width-1:0];
                        default:   alu_result = '0;
                    endcase
                end
                // addi and the immediate address forms share the adder
                op_addi, op_lwi, op_swi:
                begin
                    alu_result   = add_out[data_width-1:0];
                    alu_overflow = add_out[data_width];
                end
                op_ori:  alu_result = src1 | src2;
                op_xori: alu_result = src1 ^ src2;
                op_movi: alu_result = src1;
                op_ty_ls:
                begin
                    if (sub_op_ls == ls_lw || sub_op_ls == ls_sw)
                    begin
                        alu_result   = add_out[data_width-1:0];
                        alu_overflow = add_out[data_width];
                    end
                end
                default:
                begin
                    alu_result   = '0;
                    alu_overflow = 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [core_pkg::reg_addr_width-1:0] read_a_addr,
    input  logic [core_pkg::reg_addr_width-1:0] read_b_addr,
    output logic [core_pkg::data_width-1:0]     read_a_data,
    output logic [core_pkg::data_width-1:0]     read_b_data,
    input  logic                                write_en,
    input  logic [core_pkg::reg_addr_width-1:0] write_addr,
    input  logic [core_pkg::data_width-1:0]     write_data
);
    import core_pkg::*;

    logic [data_width-1:0] regs [1 << reg_addr_width];
    logic                  bypass_a;
    logic                  bypass_b;

    // same-edge write wins over the stored value
    assign bypass_a = write_en && (write_addr == read_a_addr);
    assign bypass_b = write_en && (write_addr == read_b_addr);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < (1 << reg_addr_width); i++)
            begin
                regs[i] <= '0;
            end
            read_a_data <= '0;
            read_b_data <= '0;
        end
        else
        begin
            if (write_en)
            begin
                regs[write_addr] <= write_data;
            end
            read_a_data <= bypass_a ? write_data : regs[read_a_addr];
            read_b_data <= bypass_b ? write_data : regs[read_b_addr];
        end
    end

endmodule

/* source/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  logic [31:0]                         instr,
    output logic [core_pkg::reg_addr_width-1:0] read_a_addr,
    output logic [core_pkg::reg_addr_width-1:0] read_b_addr,
    output core_pkg::opcode_e                   opcode,
    output core_pkg::base_sub_e                 sub_op_base,
    output core_pkg::ls_sub_e                   sub_op_ls,
    output logic [core_pkg::data_width-1:0]     imm,
    output logic                                src1_imm,
    output logic                                src2_imm,
    output logic [core_pkg::reg_addr_width-1:0] rd_addr,
    output logic                                reg_write,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic                                exec_valid
);
    import core_pkg::*;

    opcode_e               dec_opcode;
    base_sub_e             dec_sub_base;
    ls_sub_e               dec_sub_ls;
    logic [data_width-1:0] dec_imm;
    logic                  dec_shift;
    logic                  dec_load;
    logic                  dec_store;
    logic                  dec_src2_imm;

    assign dec_opcode   = opcode_e'(instr[30:25]);
    assign dec_sub_base = base_sub_e'(instr[4:0]);
    assign dec_sub_ls   = ls_sub_e'(instr[7:0]);

    assign dec_shift = (dec_opcode == op_ty_base) &&
                       (dec_sub_base inside {sub_slli, sub_srli, sub_rotri});
    assign dec_load  = (dec_opcode == op_lwi) ||
                       ((dec_opcode == op_ty_ls) && (dec_sub_ls == ls_lw));
    assign dec_store = (dec_opcode == op_swi) ||
                       ((dec_opcode == op_ty_ls) && (dec_sub_ls == ls_sw));

    // sw has no immediate, so its address is ra + 0
    assign dec_src2_imm = (dec_opcode inside {op_addi, op_ori, op_xori, op_lwi, op_swi}) ||
                          dec_shift || dec_store;

    // stores read rt on port b as the data to write
    assign read_a_addr = instr[19:15];
    assign read_b_addr = dec_store ? instr[24:20] : instr[14:10];

    always_comb
    begin
        case (dec_opcode)
            op_addi, op_lwi, op_swi:
                dec_imm = {{(data_width - 15){instr[14]}}, instr[14:0]};
            op_ori, op_xori:
                dec_imm = {{(data_width - 15){1'b0}}, instr[14:0]};
            op_movi:
                dec_imm = {{(data_width - 20){instr[19]}}, instr[19:0]};
            // shift amount from the rb field
            op_ty_base:
                dec_imm = {{(data_width - 5){1'b0}}, instr[14:10]};
            default:
                dec_imm = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exec_valid <= 1'b0;
            reg_write  <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
        end
        else
        begin
            exec_valid <= instr_valid;
            reg_write  <= instr_valid && !dec_store;
            mem_read   <= instr_valid && dec_load;
            mem_write  <= instr_valid && dec_store;
        end
    end

    // stage fields
    always_ff @(posedge clk)
    begin
        if (instr_valid)
        begin
            opcode      <= dec_opcode;
            sub_op_base <= dec_sub_base;
            sub_op_ls   <= dec_sub_ls;
            imm         <= dec_imm;
            src1_imm    <= (dec_opcode == op_movi);
            src2_imm    <= dec_src2_imm;
            rd_addr     <= instr[24:20];
        end
    end

endmodule

/* source/core_pkg.sv */
package core_pkg;

    // word and register index widths
    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    // major opcodes, instr[30:25]
    typedef enum logic [5:0] {
        op_lwi     = 6'h02,
        op_swi     = 6'h0a,
        op_ty_ls   = 6'h1c,
        op_ty_base = 6'h20,
        op_movi    = 6'h22,
        op_addi    = 6'h28,
        op_xori    = 6'h2b,
        op_ori     = 6'h2c
    } opcode_e;

    // sub-opcodes under op_ty_base, instr[4:0]
    typedef enum logic [4:0] {
        sub_add   = 5'd0,
        sub_sub   = 5'd1,
        sub_and   = 5'd2,
        sub_xor   = 5'd3,
        sub_or    = 5'd4,
        sub_slli  = 5'd8,
        sub_srli  = 5'd9,
        sub_rotri = 5'd11
    } base_sub_e;

    // sub-opcodes under op_ty_ls, instr[7:0]
    typedef enum logic [7:0] {
        ls_lw = 8'h02,
        ls_sw = 8'h0a
    } ls_sub_e;

endpackage
